// ==== videoPkg.sv ====
// Video channel widths, luma and position types, pixel region kinds
package videoPkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int colorWidth = 10; // One RGB channel
  localparam int lumaWidth  = 10; // Gray sample
  localparam int posWidth   = 11; // Covers 2047 columns or rows

  // ----------------------------------------
  // Sample and position types
  // ----------------------------------------
  typedef logic [lumaWidth-1:0] luma_t;
  typedef logic [posWidth-1:0]  pos_t;

  // Full white after binarization
  localparam luma_t lumaMax = '1;

  // ----------------------------------------
  // Pixel treatment in the output stage
  // ----------------------------------------
  // Gray outside the corner region, binary inside it
  typedef enum logic {
    pixGray,   // Luma passes unchanged
    pixBinary  // Luma forced to white or black
  } pixKind_e;

endpackage

// ==== displayPkg.sv ====
// Seven-segment display types, BCD digit type, digit count and segment patterns
package displayPkg;

  // ----------------------------------------
  // Display sizes and types
  // ----------------------------------------
  localparam int digitCount = 4; // Ones, tens, hundreds, thousands

  typedef logic [3:0] bcd_t;  // One decimal digit
  typedef logic [6:0] seg_t;  // Segments g..a, active low

  // ----------------------------------------
  // Patterns indexed by digit value
  // ----------------------------------------
  // Codes above 9 give a dark display
  localparam seg_t segTable [16] = '{
    7'b1000000, // 0
    7'b1111001, // 1
    7'b0100100, // 2
    7'b0110000, // 3
    7'b0011001, // 4
    7'b0010010, // 5
    7'b0000010, // 6
    7'b1111000, // 7
    7'b0000000, // 8
    7'b0010000, // 9
    7'b1111111, // Blank
    7'b1111111,
    7'b1111111,
    7'b1111111,
    7'b1111111,
    7'b1111111
  };

endpackage

// ==== pixelIf.sv ====
// pixelIf interface: one luma pixel with its position, src and dst modports
`timescale 1ns/1ps

interface pixelIf import videoPkg::*; ();

  logic  valid; // Pixel present this cycle, no stall
  luma_t luma;  // Gray sample
  pos_t  x;     // Column within the line
  pos_t  y;     // Line within the frame

  // Producing stage
  modport src (
    output valid,
    output luma,
    output x,
    output y
  );

  // Consuming stage
  modport dst (
    input valid,
    input luma,
    input x,
    input y
  );

endinterface

// ==== lumaCapture.sv ====
// lumaCapture module: pixel position counters and RGB to luma shift sum
`timescale 1ns/1ps

module lumaCapture import videoPkg::*; #(
  parameter int lineWidth = 640
) (
  input  logic                  OSC_50,
  input  logic                  KEY,
  input  logic                  pixValid,
  input  logic                  lineStart,
  input  logic                  frameStart,
  input  logic [colorWidth-1:0] red,
  input  logic [colorWidth-1:0] green,
  input  logic [colorWidth-1:0] blue,
  pixelIf.src                   pixOut
);

  pos_t  xCnt, yCnt; // Position of the next pixel
  pos_t  xCur, yCur; // Position of the pixel at the input now
  luma_t lumaSum;

  // Quarter red, half green, eighth blue, at most 893
  assign lumaSum = luma_t'(red >> 2) + luma_t'(green >> 1) + luma_t'(blue >> 3);

  // ----------------------------------------
  // Position of the incoming pixel
  // ----------------------------------------
  always_comb
  begin
    xCur = lineStart ? '0 : xCnt; // Marker pixel is column 0
    if (frameStart)
      yCur = '0;
    else if (lineStart)
      yCur = yCnt + 1'b1; // New line
    else
      yCur = yCnt;
  end

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      xCnt <= '0;
      yCnt <= '0;
    end
    else if (pixValid)
    begin
      // Column wraps at the line length so it never leaves the buffer range
      xCnt <= (xCur == pos_t'(lineWidth - 1)) ? '0 : xCur + 1'b1;
      yCnt <= yCur;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      pixOut.valid <= 1'b0;
    else
      pixOut.valid <= pixValid;
  end

  always_ff @(posedge OSC_50)
  begin
    if (pixValid)
    begin
      pixOut.luma <= lumaSum;
      pixOut.x    <= xCur;
      pixOut.y    <= yCur;
    end
  end

  // Line and frame markers ride on a real pixel
  markerOnPixel: assert property (@(posedge OSC_50) disable iff (!KEY)
    (lineStart || frameStart) |-> pixValid);

endmodule

// ==== lineAverager.sv ====
// lineAverager module: two chained line buffers and the vertical three-line luma filter
`timescale 1ns/1ps

module lineAverager import videoPkg::*; #(
  parameter int lineWidth = 640
) (
  input  logic OSC_50,
  input  logic KEY,
  pixelIf.dst  pixIn,
  pixelIf.src  pixOut
);

  luma_t lineOne [lineWidth]; // One line of delay
  luma_t lineTwo [lineWidth]; // Second line of delay, fed by the first

  luma_t oneBack;   // Same column, previous line
  luma_t twoBack;   // Same column, two lines up
  logic [lumaWidth:0] outerSum; // Current plus twoBack, one extra bit
  luma_t lumaFilt;

  // ----------------------------------------
  // Line buffers
  // ----------------------------------------
  // Tail entries hold the samples pushed exactly one and two lines ago
  assign oneBack = lineOne[lineWidth-1];
  assign twoBack = lineTwo[lineWidth-1];

  always_ff @(posedge OSC_50)
  begin
    if (pixIn.valid) // Gaps do not shift
    begin
      lineOne[0] <= pixIn.luma;
      lineTwo[0] <= oneBack;     // Chain the two buffers
      for (int i = 1; i < lineWidth; i++)
      begin
        lineOne[i] <= lineOne[i-1];
        lineTwo[i] <= lineTwo[i-1];
      end
    end
  end

  // ----------------------------------------
  // Quarter, half, quarter filter
  // ----------------------------------------
  assign outerSum = {1'b0, pixIn.luma} + {1'b0, twoBack};

  // Each term truncated on its own, sum tops out at 1022
  assign lumaFilt = luma_t'(outerSum >> 2) + luma_t'(oneBack >> 1);

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      pixOut.valid <= 1'b0;
    else
      pixOut.valid <= pixIn.valid;
  end

  always_ff @(posedge OSC_50)
  begin
    if (pixIn.valid)
    begin
      pixOut.luma <= lumaFilt;
      pixOut.x    <= pixIn.x;   // Position follows its pixel
      pixOut.y    <= pixIn.y;
    end
  end

  // Column from the capture stage must fit the buffer length
  colInRange: assert property (@(posedge OSC_50) disable iff (!KEY)
    pixIn.valid |-> (pixIn.x < pos_t'(lineWidth)));

endmodule

// ==== thresholdStage.sv ====
// thresholdStage module: region classification and luma binarization against a threshold
`timescale 1ns/1ps

module thresholdStage import videoPkg::*; #(
  parameter int regionX = 320,
  parameter int regionY = 240
) (
  input  logic  OSC_50,
  input  logic  KEY,
  pixelIf.dst   pixIn,
  input  luma_t threshold,
  output logic  outValid,
  output luma_t outLuma
);

  pixKind_e pixKind;

  // ----------------------------------------
  // Region select
  // ----------------------------------------
  // Lower-right corner, both bounds exclusive
  always_comb
  begin
    if (pixIn.x > pos_t'(regionX) && pixIn.y > pos_t'(regionY))
      pixKind = pixBinary;
    else
      pixKind = pixGray;
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      outValid <= 1'b0;
    else
      outValid <= pixIn.valid;
  end

  always_ff @(posedge OSC_50)
  begin
    if (pixIn.valid)
    begin
      case (pixKind)
        pixBinary: outLuma <= (pixIn.luma > threshold) ? lumaMax : '0; // Equal gives black
        default:   outLuma <= pixIn.luma;                             // Gray passthrough
      endcase
    end
  end

endmodule

// ==== uptimeDisplay.sv ====
// uptimeDisplay module: seconds divider, four-digit BCD counter and segment decode
`timescale 1ns/1ps

module uptimeDisplay import displayPkg::*; #(
  parameter int ticksPerSecond = 50_000_000
) (
  input  logic OSC_50,
  input  logic KEY,
  output seg_t hex0,
  output seg_t hex1,
  output seg_t hex2,
  output seg_t hex3
);

  localparam int tickWidth = $clog2(ticksPerSecond + 1);

  logic [tickWidth-1:0] tickCnt;
  logic secondWrap;            // Last cycle of the second
  bcd_t digits    [digitCount]; // Index 0 is ones
  bcd_t digitNext [digitCount];

  // ----------------------------------------
  // Seconds divider
  // ----------------------------------------
  assign secondWrap = (tickCnt == tickWidth'(ticksPerSecond - 1));

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
      tickCnt <= '0;
    else if (secondWrap)
      tickCnt <= '0;
    else
      tickCnt <= tickCnt + 1'b1;
  end

  // ----------------------------------------
  // BCD ripple carry
  // ----------------------------------------
  always_comb
  begin
    logic carryIn;
    carryIn = secondWrap;
    for (int i = 0; i < digitCount; i++)
    begin
      digitNext[i] = digits[i];
      if (carryIn)
      begin
        if (digits[i] == bcd_t'(9))
          digitNext[i] = '0;              // Roll over, carry goes on
        else
        begin
          digitNext[i] = digits[i] + 1'b1;
          carryIn = 1'b0;                 // Carry absorbed here
        end
      end
    end
  end

  always_ff @(posedge OSC_50 or negedge KEY)
  begin
    if (!KEY)
    begin
      for (int i = 0; i < digitCount; i++)
        digits[i] <= '0;
    end
    else
      digits <= digitNext; // Whole count moves on the wrap edge
  end

  // Segment decode
  assign hex0 = segTable[digits[0]];
  assign hex1 = segTable[digits[1]];
  assign hex2 = segTable[digits[2]];
  assign hex3 = segTable[digits[3]];

  // Every digit stays decimal across all seconds
  for (genvar g = 0; g < digitCount; g++)
  begin : digitCheck
    digitDecimal: assert property (@(posedge OSC_50) disable iff (!KEY)
      digits[g] <= bcd_t'(9));
  end

endmodule

// ==== tvThreshold.sv ====
// tvThreshold top level: luma pipeline stages, pixel links and uptime display
`timescale 1ns/1ps

module tvThreshold import videoPkg::*, displayPkg::*; #(
  parameter int lineWidth      = 640,
  parameter int regionX        = 320,
  parameter int regionY        = 240,
  parameter int ticksPerSecond = 50_000_000
) (
  input  logic                  OSC_50,     // 50 MHz
  input  logic                  KEY,        // Reset, low active
  input  logic                  pixValid,
  input  logic                  lineStart,
  input  logic                  frameStart,
  input  logic [colorWidth-1:0] red,
  input  logic [colorWidth-1:0] green,
  input  logic [colorWidth-1:0] blue,
  input  luma_t                 threshold,
  output logic                  outValid,   // Three cycles after pixValid
  output luma_t                 outLuma,
  output seg_t                  hex0,       // Seconds, ones
  output seg_t                  hex1,
  output seg_t                  hex2,
  output seg_t                  hex3        // Seconds, thousands
);

  // ----------------------------------------
  // Pixel pipeline
  // ----------------------------------------
  pixelIf capPix ();  // Capture to filter
  pixelIf avgPix ();  // Filter to threshold

  lumaCapture #(.lineWidth(lineWidth)) lumaCapture_i (
    .OSC_50     (OSC_50),
    .KEY        (KEY),
    .pixValid   (pixValid),
    .lineStart  (lineStart),
    .frameStart (frameStart),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .pixOut     (capPix.src)
  );

  lineAverager #(.lineWidth(lineWidth)) lineAverager_i (
    .OSC_50 (OSC_50),
    .KEY    (KEY),
    .pixIn  (capPix.dst),
    .pixOut (avgPix.src)
  );

  thresholdStage #(.regionX(regionX), .regionY(regionY)) thresholdStage_i (
    .OSC_50    (OSC_50),
    .KEY       (KEY),
    .pixIn     (avgPix.dst),
    .threshold (threshold),
    .outValid  (outValid),
    .outLuma   (outLuma)
  );

  // Uptime seconds on the displays
  uptimeDisplay #(.ticksPerSecond(ticksPerSecond)) uptimeDisplay_i (
    .OSC_50 (OSC_50),
    .KEY    (KEY),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3)
  );

endmodule

// ==== tbTvThreshold.sv ====
// Testbench with clock and reset, vector reader, output and model checks, uptime check and timeout
`timescale 1ns/1ps

module tbTvThreshold import displayPkg::*; ();

  localparam int vecCount    = 34;
  localparam int fieldCount  = 9;  // Values per vector line
  localparam int resetCycles = 10;
  localparam int latency     = 3;
  localparam int idleCycles  = 130;
  localparam int cycleLimit  = vecCount + resetCycles + latency + idleCycles + 20;
  localparam int pixPerLine  = 8;
  localparam int cornerX     = 3;
  localparam int cornerY     = 2;
  localparam int ticksSec    = 4;
  localparam int white       = 1023;

  // Field positions within a vector
  localparam int fValid = 0, fLine = 1, fFrame = 2, fRed = 3, fGreen = 4;
  localparam int fBlue = 5, fThr = 6, fChk = 7, fExp = 8;

  logic       OSC_50;
  logic       KEY;
  logic       pixValid;
  logic       lineStart;
  logic       frameStart;
  logic [9:0] red;
  logic [9:0] green;
  logic [9:0] blue;
  logic [9:0] threshold;
  logic       outValid;
  logic [9:0] outLuma;
  seg_t       hex0, hex1, hex2, hex3;

  logic [9:0] vecMem [vecCount * fieldCount];
  int cycleCnt = 0;
  int relCyc;                                    // Edge count at reset release
  int lumaErrs, validErrs, fileErrs, hexErrs;

  tvThreshold #(
    .lineWidth      (pixPerLine),
    .regionX        (cornerX),
    .regionY        (cornerY),
    .ticksPerSecond (ticksSec)
  ) dut_i (
    .OSC_50     (OSC_50),
    .KEY        (KEY),
    .pixValid   (pixValid),
    .lineStart  (lineStart),
    .frameStart (frameStart),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .threshold  (threshold),
    .outValid   (outValid),
    .outLuma    (outLuma),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3)
  );

  // ----------------------------------------
  // Clock and cycle limit
  // ----------------------------------------
  initial
  begin
    OSC_50 = 1'b0;
    forever #20 OSC_50 = ~OSC_50; // 40 ns period
  end

  always @(posedge OSC_50)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= cycleLimit)
    begin
      $display("Timeout: run still going after %0d cycles", cycleCnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Vector access and reference model
  // ----------------------------------------
  function automatic logic [9:0] vecField(int v, int f);
    return vecMem[v * fieldCount + f];
  endfunction

  function automatic logic fieldSet(int v, int f);
    return vecField(v, f) != 10'd0;
  endfunction

  // Quarter red, half green, eighth blue
  function automatic int lumaOf(int r, int g, int b);
    return r / 4 + g / 2 + b / 8;
  endfunction

  // Recompute every checked expected value from the colours
  task automatic checkVectorFile();
    int hist [$];  // Luma of every valid pixel so far
    int xPos;
    int yPos;
    int cur;
    int model;
    int n;
    xPos = 0;
    yPos = 0;
    for (int v = 0; v < vecCount; v++)
    begin
      if (fieldSet(v, fValid))
      begin
        if (fieldSet(v, fLine))
          xPos = 0;
        if (fieldSet(v, fFrame))
          yPos = 0;
        else if (fieldSet(v, fLine))
          yPos = yPos + 1;
        cur = lumaOf(vecField(v, fRed), vecField(v, fGreen), vecField(v, fBlue));
        n = hist.size();
        if (fieldSet(v, fChk) && n < 2 * pixPerLine)
        begin
          fileErrs++;
          $display("Vector %0d is checked before two lines are stored", v);
        end
        else if (fieldSet(v, fChk))
        begin
          model = (cur + hist[n - 2 * pixPerLine]) / 4 + hist[n - pixPerLine] / 2;
          if (xPos > cornerX && yPos > cornerY)
            model = (model > int'(vecField(v, fThr))) ? white : 0; // Equal gives black
          if (model != int'(vecField(v, fExp)))
          begin
            fileErrs++;
            $display("FAILED expectedLuma of vector %0d: file %h model %h",
                     v, vecField(v, fExp), model);
          end
        end
        hist.push_back(cur);
        xPos = xPos + 1;
      end
    end
  endtask

  // ----------------------------------------
  // Drive and check
  // ----------------------------------------
  task automatic driveVector(int idx);
    if (idx < vecCount)
    begin
      pixValid   <= fieldSet(idx, fValid);
      lineStart  <= fieldSet(idx, fLine);
      frameStart <= fieldSet(idx, fFrame);
      red        <= vecField(idx, fRed);
      green      <= vecField(idx, fGreen);
      blue       <= vecField(idx, fBlue);
    end
    else
    begin
      pixValid   <= 1'b0; // Idle input
      lineStart  <= 1'b0;
      frameStart <= 1'b0;
    end
    // Output stage sees a pixel two cycles after capture
    if (idx >= 2 && idx - 2 < vecCount)
      threshold <= vecField(idx - 2, fThr);
  endtask

  // Negative index means no pixel due at the output
  task automatic checkOutputs(int idx);
    logic expValid;
    expValid = (idx >= 0) ? fieldSet(idx, fValid) : 1'b0;
    if (outValid !== expValid)
    begin
      validErrs++;
      $display("FAILED outValid at vector %0d: got %h expected %h", idx, outValid, expValid);
    end
    if (idx >= 0)
    begin
      if (fieldSet(idx, fChk) && outLuma !== vecField(idx, fExp))
      begin
        lumaErrs++;
        $display("FAILED outLuma at vector %0d: got %h expected %h",
                 idx, outLuma, vecField(idx, fExp));
      end
    end
  endtask

  // Whole seconds since release with the ones digit first
  task automatic checkUptime();
    int secs;
    seg_t expSeg [4];
    seg_t gotSeg [4];
    secs = (cycleCnt - relCyc) / ticksSec;
    gotSeg[0] = hex0;
    gotSeg[1] = hex1;
    gotSeg[2] = hex2;
    gotSeg[3] = hex3;
    for (int i = 0; i < 4; i++)
    begin
      expSeg[i] = segTable[secs % 10];
      secs = secs / 10;
      if (gotSeg[i] !== expSeg[i])
      begin
        hexErrs++;
        $display("FAILED hex%0d: got %h expected %h", i, gotSeg[i], expSeg[i]);
      end
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    KEY        = 1'b0;
    pixValid   = 1'b0;
    lineStart  = 1'b0;
    frameStart = 1'b0;
    red        = '0;
    green      = '0;
    blue       = '0;
    threshold  = '0;
    $readmemh("tvThreshold_vectors.txt", vecMem);
    if (vecMem[fValid] !== 10'h001)
    begin
      fileErrs++;
      $display("Vector file missing or its first line is not a pixel");
    end
    checkVectorFile();

    repeat (resetCycles)
    begin
      @(negedge OSC_50);
      checkOutputs(-1);   // Low all through reset
    end
    @(posedge OSC_50);
    KEY <= 1'b1;
    @(negedge OSC_50);
    relCyc = cycleCnt;

    // Vector j driven at edge j shows at the outputs three edges later
    for (int j = 0; j < vecCount + latency; j++)
    begin
      @(posedge OSC_50);
      driveVector(j);
      @(negedge OSC_50);
      checkOutputs(j - latency);
    end

    repeat (idleCycles)
    begin
      @(negedge OSC_50);
      checkOutputs(-1);
    end
    // Mid-second and clear of the wrap edge
    while ((cycleCnt - relCyc) % ticksSec != 2)
      @(negedge OSC_50);
    checkUptime();

    $display("Errors: outLuma %0d, outValid %0d, vector file %0d, hex %0d",
             lumaErrs, validErrs, fileErrs, hexErrs);
    if (lumaErrs + validErrs + fileErrs + hexErrs == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tvThreshold.f ====
videoPkg.sv
displayPkg.sv
pixelIf.sv
lumaCapture.sv
lineAverager.sv
thresholdStage.sv
uptimeDisplay.sv
tvThreshold.sv
tbTvThreshold.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build tbTvThreshold with Verilator, run it into sim.log, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tbTvThreshold -f tvThreshold.f -o simTv \
  && ./obj_dir/simTv | tee sim.log \
  && grep -qx "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tvThreshold_vectors.txt ====
// Columns in hex: pixValid lineStart frameStart red green blue threshold checkFlag expectedLuma
// One line per input cycle, threshold belongs to the pixel on the same line
// Line 0, colour A, buffers still filling
1 1 1 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
// Line 1, colour A again
1 1 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
1 0 0 100 080 040 000 0 000
// Line 2, colour B after two lines of A, one idle gap
1 1 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
0 0 0 000 000 000 000 0 000
1 0 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
1 0 0 203 1FF 00F 000 1 0C6
// Line 3, gray up to column 3, binary from column 4
1 1 0 3FF 3FF 3FF 200 1 1C1
1 0 0 001 001 007 200 1 0E2
1 0 0 00E 005 017 200 1 0E3
1 0 0 100 080 040 000 1 104
1 0 0 100 080 040 104 1 000
1 0 0 100 080 040 103 1 3FF
0 0 0 000 000 000 000 0 000
1 0 0 001 001 007 100 1 000
1 0 0 3FF 3FF 3FF 1C0 1 3FF
